// ==== verilog/dot11_tx_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// 802.11a transmit bit generator definitions
// Field encoding, packet memory geometry, legacy rate table and the
// scrambler, CRC-32 and convolutional code constants
////////////////////////////////////////////////////////////////////////////

package dot11_tx_pkg;

    // Packet memory geometry
    localparam int MEM_WORD_W  = 64;
    localparam int MEM_ADDR_W  = 10;

    // SIGNAL word layout in memory word 0
    localparam int SIG_LEN_LSB = 5;
    localparam int SIG_LEN_MSB = 16;

    // Field lengths in bits
    localparam int SIG_BITS     = 24;
    localparam int SERVICE_BITS = 16;
    localparam int TAIL_BITS    = 6;
    localparam int FCS_BITS     = 32;

    // Counter widths
    localparam int BIT_IDX_W  = 6;
    localparam int PSDU_CNT_W = 15;
    localparam int DBPS_W     = 9;
    localparam int SCRAM_W    = 7;

    typedef logic [MEM_WORD_W-1:0] mem_word_t;
    typedef logic [MEM_ADDR_W-1:0] mem_addr_t;
    typedef logic [BIT_IDX_W-1:0]  bit_idx_t;
    typedef logic [PSDU_CNT_W-1:0] psdu_cnt_t;
    typedef logic [DBPS_W-1:0]     dbps_t;

    // Bit currently on its way to the encoder
    typedef enum logic [2:0] {
        IDLE,
        SIGNAL,
        SERVICE,
        PSDU,
        FCS,
        TAIL,
        PAD
    } tx_field_t;

    // Legacy rate codes and their data bits per OFDM symbol
    localparam logic [3:0] RATE_6M  = 4'b1011;
    localparam dbps_t      DBPS_6M  = 9'd24;
    localparam logic [3:0] RATE_9M  = 4'b1111;
    localparam dbps_t      DBPS_9M  = 9'd36;
    localparam logic [3:0] RATE_12M = 4'b1010;
    localparam dbps_t      DBPS_12M = 9'd48;
    localparam logic [3:0] RATE_18M = 4'b1110;
    localparam dbps_t      DBPS_18M = 9'd72;
    localparam logic [3:0] RATE_24M = 4'b1001;
    localparam dbps_t      DBPS_24M = 9'd96;
    localparam logic [3:0] RATE_36M = 4'b1101;
    localparam dbps_t      DBPS_36M = 9'd144;
    localparam logic [3:0] RATE_48M = 4'b1000;
    localparam dbps_t      DBPS_48M = 9'd192;
    localparam logic [3:0] RATE_54M = 4'b1100;
    localparam dbps_t      DBPS_54M = 9'd216;

    // Reflected IEEE CRC-32
    localparam logic [FCS_BITS-1:0] CRC_POLY = 32'hEDB88320;
    localparam logic [FCS_BITS-1:0] CRC_INIT = 32'hFFFFFFFF;

    // K=7 code, generators in octal, MSB is the current input bit
    localparam int                CONV_K  = 7;
    localparam logic [CONV_K-1:0] CONV_G0 = 7'o133;
    localparam logic [CONV_K-1:0] CONV_G1 = 7'o171;

endpackage

// ==== verilog/dot11_field_if.sv ====
////////////////////////////////////////////////////////////////////////////
// Field sequencing bundle
// Current field, bit position and step strobes from the frame
// sequencer to the bit source
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

interface dot11_field_if;

    dot11_tx_pkg::tx_field_t field;
    dot11_tx_pkg::bit_idx_t  bit_idx;
    // Current bit consumed this cycle
    logic                    step;
    // Seed load for the scrambler, CRC restart
    logic                    start_data;
    // Encoder history clear
    logic                    sig_end;

    modport seq (output field, output bit_idx, output step, output start_data, output sig_end);

    modport src (input field, input bit_idx, input step, input start_data, input sig_end);

endinterface

// ==== verilog/dot11_frame_seq.sv ====
////////////////////////////////////////////////////////////////////////////
// 802.11a frame sequencer
// Walks SIGNAL and the DATA sub-fields one bit per transfer, addresses
// the packet memory and pads to a whole number of OFDM symbols
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module dot11_frame_seq (
    input  logic                    clk,
    input  logic                    reset_int,
    input  logic                    i_start,
    input  dot11_tx_pkg::mem_word_t i_mem_data,
    input  logic                    i_ready,
    output dot11_tx_pkg::mem_addr_t o_mem_addr,
    output logic                    o_valid,
    output logic                    o_busy,
    output logic                    o_done,
    dot11_field_if.seq              fld
);

    dot11_tx_pkg::tx_field_t field;
    dot11_tx_pkg::bit_idx_t  bit_cnt;
    dot11_tx_pkg::psdu_cnt_t psdu_cnt;
    dot11_tx_pkg::psdu_cnt_t psdu_last;
    dot11_tx_pkg::dbps_t     n_dbps;
    dot11_tx_pkg::dbps_t     dbps_dec;
    dot11_tx_pkg::dbps_t     sym_cnt;
    dot11_tx_pkg::mem_addr_t mem_addr;
    logic [dot11_tx_pkg::SIG_LEN_MSB-dot11_tx_pkg::SIG_LEN_LSB:0] sig_len;
    logic                    done;
    logic                    accept;
    logic                    xfer;
    logic                    sig_last;
    logic                    svc_last;
    logic                    fcs_last;
    logic                    tail_last;
    logic                    sym_wrap;
    logic                    data_go;
    logic                    finish;

    assign sig_len = i_mem_data[dot11_tx_pkg::SIG_LEN_MSB:dot11_tx_pkg::SIG_LEN_LSB];
    assign accept  = (field == dot11_tx_pkg::IDLE) && i_start;
    assign xfer    = (field != dot11_tx_pkg::IDLE) && i_ready;

    assign sig_last  = bit_cnt == dot11_tx_pkg::bit_idx_t'(dot11_tx_pkg::SIG_BITS - 1);
    assign svc_last  = bit_cnt == dot11_tx_pkg::bit_idx_t'(dot11_tx_pkg::SERVICE_BITS - 1);
    assign fcs_last  = bit_cnt == dot11_tx_pkg::bit_idx_t'(dot11_tx_pkg::FCS_BITS - 1);
    assign tail_last = bit_cnt == dot11_tx_pkg::bit_idx_t'(dot11_tx_pkg::TAIL_BITS - 1);
    assign sym_wrap  = sym_cnt == n_dbps - 1'b1;

    assign data_go = xfer && (field == dot11_tx_pkg::SIGNAL) && sig_last;
    // Last DATA bit closes a symbol, either right after the tail or in the pad
    assign finish  = xfer && sym_wrap && (((field == dot11_tx_pkg::TAIL) && tail_last) ||
                                          (field == dot11_tx_pkg::PAD));

    // Rate code in bits 3:0 of the SIGNAL word
    always_comb begin
        case (i_mem_data[3:0])
            dot11_tx_pkg::RATE_6M:  dbps_dec = dot11_tx_pkg::DBPS_6M;
            dot11_tx_pkg::RATE_9M:  dbps_dec = dot11_tx_pkg::DBPS_9M;
            dot11_tx_pkg::RATE_12M: dbps_dec = dot11_tx_pkg::DBPS_12M;
            dot11_tx_pkg::RATE_18M: dbps_dec = dot11_tx_pkg::DBPS_18M;
            dot11_tx_pkg::RATE_24M: dbps_dec = dot11_tx_pkg::DBPS_24M;
            dot11_tx_pkg::RATE_36M: dbps_dec = dot11_tx_pkg::DBPS_36M;
            dot11_tx_pkg::RATE_48M: dbps_dec = dot11_tx_pkg::DBPS_48M;
            dot11_tx_pkg::RATE_54M: dbps_dec = dot11_tx_pkg::DBPS_54M;
            default:                dbps_dec = dot11_tx_pkg::DBPS_6M;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Field state machine
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset_int) begin
            field     <= dot11_tx_pkg::IDLE;
            bit_cnt   <= '0;
            psdu_cnt  <= '0;
            psdu_last <= '0;
            n_dbps    <= dot11_tx_pkg::DBPS_6M;
            sym_cnt   <= '0;
            mem_addr  <= '0;
            done      <= 1'b0;
        end else begin
            done <= 1'b0;
            if (accept) begin
                // Word 0 is on the bus while idle
                field     <= dot11_tx_pkg::SIGNAL;
                bit_cnt   <= '0;
                psdu_cnt  <= '0;
                sym_cnt   <= '0;
                n_dbps    <= dbps_dec;
                psdu_last <= {sig_len, 3'b000} -
                             dot11_tx_pkg::psdu_cnt_t'(dot11_tx_pkg::FCS_BITS + 1);
            end else if (xfer) begin
                bit_cnt <= bit_cnt + 1'b1;
                if (field != dot11_tx_pkg::SIGNAL) begin
                    sym_cnt <= sym_wrap ? '0 : sym_cnt + 1'b1;
                end
                case (field)
                    dot11_tx_pkg::SIGNAL: begin
                        if (sig_last) begin
                            field    <= dot11_tx_pkg::SERVICE;
                            bit_cnt  <= '0;
                            mem_addr <= dot11_tx_pkg::mem_addr_t'(1);
                        end
                    end
                    dot11_tx_pkg::SERVICE: begin
                        if (svc_last) begin
                            field   <= dot11_tx_pkg::PSDU;
                            bit_cnt <= '0;
                        end
                    end
                    dot11_tx_pkg::PSDU: begin
                        psdu_cnt <= psdu_cnt + 1'b1;
                        // Next word once bit 63 of this one is taken
                        if (&bit_cnt) begin
                            mem_addr <= mem_addr + 1'b1;
                        end
                        if (psdu_cnt == psdu_last) begin
                            field   <= dot11_tx_pkg::FCS;
                            bit_cnt <= '0;
                        end
                    end
                    dot11_tx_pkg::FCS: begin
                        if (fcs_last) begin
                            field   <= dot11_tx_pkg::TAIL;
                            bit_cnt <= '0;
                        end
                    end
                    dot11_tx_pkg::TAIL: begin
                        if (tail_last) begin
                            field   <= dot11_tx_pkg::PAD;
                            bit_cnt <= '0;
                        end
                    end
                    default: begin
                    end
                endcase
                if (finish) begin
                    field    <= dot11_tx_pkg::IDLE;
                    mem_addr <= '0;
                    done     <= 1'b1;
                end
            end
        end
    end

    assign o_mem_addr = mem_addr;
    assign o_valid    = field != dot11_tx_pkg::IDLE;
    assign o_busy     = field != dot11_tx_pkg::IDLE;
    assign o_done     = done;

    assign fld.field      = field;
    assign fld.bit_idx    = bit_cnt;
    assign fld.step       = xfer;
    assign fld.start_data = data_go;
    // Encoder starts clean for SIGNAL and again for DATA
    assign fld.sig_end    = accept || data_go;

    // The packet must hold at least one payload byte besides the FCS
    assert property (@(posedge clk) disable iff (reset_int)
        accept |-> (sig_len >= 12'd5));

endmodule

// ==== verilog/dot11_bit_source.sv ====
////////////////////////////////////////////////////////////////////////////
// 802.11a bit source
// Picks the raw bit of the current field, computes the FCS and applies
// the seven-bit data scrambler
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module dot11_bit_source (
    input  logic                              clk,
    input  logic                              reset_int,
    input  dot11_tx_pkg::mem_word_t           i_mem_data,
    input  logic [dot11_tx_pkg::SCRAM_W-1:0]  i_scram_seed,
    dot11_field_if.src                        fld,
    output logic                              o_raw_bit
);

    logic [dot11_tx_pkg::SCRAM_W-1:0]  lfsr;
    logic [dot11_tx_pkg::FCS_BITS-1:0] crc;
    logic                              mem_bit;
    logic                              scr_bit;
    logic                              scr_field;
    logic                              crc_fb;

    assign mem_bit   = i_mem_data[fld.bit_idx];
    // x^7 + x^4 + 1
    assign scr_bit   = lfsr[6] ^ lfsr[3];
    assign scr_field = fld.field inside {dot11_tx_pkg::SERVICE, dot11_tx_pkg::PSDU,
                                         dot11_tx_pkg::FCS, dot11_tx_pkg::PAD};
    assign crc_fb    = crc[0] ^ mem_bit;

    always_comb begin
        case (fld.field)
            dot11_tx_pkg::SIGNAL:  o_raw_bit = mem_bit;
            dot11_tx_pkg::SERVICE: o_raw_bit = scr_bit;
            dot11_tx_pkg::PSDU:    o_raw_bit = mem_bit ^ scr_bit;
            // FCS goes out complemented, bit 0 first
            dot11_tx_pkg::FCS:     o_raw_bit = ~crc[fld.bit_idx[4:0]] ^ scr_bit;
            dot11_tx_pkg::PAD:     o_raw_bit = scr_bit;
            default:               o_raw_bit = 1'b0;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Scrambler and serial CRC-32
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset_int) begin
            lfsr <= '0;
            crc  <= dot11_tx_pkg::CRC_INIT;
        end else if (fld.start_data) begin
            lfsr <= i_scram_seed;
            crc  <= dot11_tx_pkg::CRC_INIT;
        end else if (fld.step) begin
            // Tail bits bypass the scrambler and leave it untouched
            if (scr_field) begin
                lfsr <= {lfsr[dot11_tx_pkg::SCRAM_W-2:0], scr_bit};
            end
            if (fld.field == dot11_tx_pkg::PSDU) begin
                crc <= {1'b0, crc[dot11_tx_pkg::FCS_BITS-1:1]} ^
                       (crc_fb ? dot11_tx_pkg::CRC_POLY : '0);
            end
        end
    end

    // FCS bits are read from a frozen CRC
    assert property (@(posedge clk) disable iff (reset_int)
        (fld.field == dot11_tx_pkg::FCS) |=> (crc == $past(crc)));

endmodule

// ==== verilog/dot11_conv_enc.sv ====
////////////////////////////////////////////////////////////////////////////
// Rate-1/2 K=7 convolutional encoder
// One g0/g1 bit pair per input bit, output combinational from history
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module dot11_conv_enc (
    input  logic       clk,
    input  logic       reset_int,
    input  logic       i_bit,
    input  logic       i_step,
    input  logic       i_clear,
    output logic [1:0] o_bits
);

    // Newest bit at the top, oldest at bit 0
    logic [dot11_tx_pkg::CONV_K-2:0] hist;
    logic [dot11_tx_pkg::CONV_K-1:0] taps;

    assign taps = {i_bit, hist};

    // g0 = 133, g1 = 171 (octal)
    assign o_bits[0] = ^(taps & dot11_tx_pkg::CONV_G0);
    assign o_bits[1] = ^(taps & dot11_tx_pkg::CONV_G1);

    always_ff @(posedge clk) begin
        if (reset_int || i_clear) begin
            hist <= '0;
        end else if (i_step) begin
            hist <= {i_bit, hist[dot11_tx_pkg::CONV_K-2:1]};
        end
    end

endmodule

// ==== verilog/dot11_bitgen_top.sv ====
////////////////////////////////////////////////////////////////////////////
// 802.11a legacy transmit bit generator
// SIGNAL and DATA bits from packet memory to coded pairs with ready stall
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module dot11_bitgen_top (
    input  logic                              clk,
    input  logic                              reset_int,
    input  logic                              i_start,
    input  logic [dot11_tx_pkg::SCRAM_W-1:0]  i_scram_seed,
    output logic [dot11_tx_pkg::MEM_ADDR_W-1:0] o_mem_addr,
    input  logic [dot11_tx_pkg::MEM_WORD_W-1:0] i_mem_data,
    output logic [1:0]                        o_bits,
    output logic                              o_valid,
    input  logic                              i_ready,
    output logic                              o_busy,
    output logic                              o_done
);

    logic raw_bit;

    dot11_field_if fld_if ();

    dot11_frame_seq seq0 (
        .clk        (clk),
        .reset_int  (reset_int),
        .i_start    (i_start),
        .i_mem_data (i_mem_data),
        .i_ready    (i_ready),
        .o_mem_addr (o_mem_addr),
        .o_valid    (o_valid),
        .o_busy     (o_busy),
        .o_done     (o_done),
        .fld        (fld_if.seq)
    );

    dot11_bit_source src0 (
        .clk          (clk),
        .reset_int    (reset_int),
        .i_mem_data   (i_mem_data),
        .i_scram_seed (i_scram_seed),
        .fld          (fld_if.src),
        .o_raw_bit    (raw_bit)
    );

    // History advances on every transferred pair
    dot11_conv_enc enc0 (
        .clk       (clk),
        .reset_int (reset_int),
        .i_bit     (raw_bit),
        .i_step    (fld_if.step),
        .i_clear   (fld_if.sig_end),
        .o_bits    (o_bits)
    );

endmodule

// ==== bench/tb_clock_gen.sv ====
////////////////////////////////////////////////////////////////////////////
// Testbench clock and reset
// 10 ns clock, reset held for the first 16 cycles
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module tb_clock_gen (
    output logic clk,
    output logic reset_int
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        reset_int = 1'b1;
        repeat (16) @(posedge clk);
        #1;
        reset_int = 1'b0;
    end

endmodule

// ==== bench/tb_dot11_bitgen.sv ====
////////////////////////////////////////////////////////////////////////////
// Testbench for the 802.11a transmit bit generator
// Packets come from the stim file, the coded stream is predicted from the
// 802.11a field rules and checked pair by pair under random back-pressure
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module tb_dot11_bitgen;

    localparam int MEM_DEPTH   = 1024;
    localparam int STIM_DEPTH  = 512;
    localparam int RESET_LIMIT = 64;
    localparam int IDLE_CHECKS = 8;

    logic        clk;
    logic        reset_int;
    logic        i_start;
    logic [6:0]  i_scram_seed;
    logic [9:0]  o_mem_addr;
    logic [63:0] i_mem_data;
    logic [1:0]  o_bits;
    logic        o_valid;
    logic        i_ready;
    logic        o_busy;
    logic        o_done;

    logic [63:0] pkt_mem [0:MEM_DEPTH-1];
    logic [31:0] stim [0:STIM_DEPTH-1];
    logic [31:0] rnd_state;
    logic [6:0]  scr_state;
    logic [7:0]  payload [$];
    logic        exp_bits [$];
    logic [1:0]  exp_pairs [$];

    // Current packet record
    logic [3:0]  pkt_rate;
    int          pkt_len;
    logic [6:0]  pkt_seed;
    logic [31:0] pkt_fcs;
    int          pkt_pairs;
    logic [23:0] pkt_sig;

    // Packet memory with asynchronous read
    assign i_mem_data = pkt_mem[o_mem_addr];

    tb_clock_gen clk_gen0 (
        .clk       (clk),
        .reset_int (reset_int)
    );

    dot11_bitgen_top dut0 (
        .clk          (clk),
        .reset_int    (reset_int),
        .i_start      (i_start),
        .i_scram_seed (i_scram_seed),
        .o_mem_addr   (o_mem_addr),
        .i_mem_data   (i_mem_data),
        .o_bits       (o_bits),
        .o_valid      (o_valid),
        .i_ready      (i_ready),
        .o_busy       (o_busy),
        .o_done       (o_done)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Reporting
    ////////////////////////////////////////////////////////////////////////////
    task automatic stop_with_failure();
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("ERR t=%0t %s got=%0h exp=%0h", $time, name, got, exp);
            stop_with_failure();
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Reference model helpers
    ////////////////////////////////////////////////////////////////////////////
    // Galois LFSR, one step per bit taken
    function automatic logic next_random_bit();
        logic lsb;
        lsb       = rnd_state[0];
        rnd_state = rnd_state >> 1;
        if (lsb) begin
            rnd_state = rnd_state ^ 32'hd000_0001;
        end
        return lsb;
    endfunction

    // Ready about three cycles in four
    function automatic logic draw_ready();
        logic a;
        logic b;
        a = next_random_bit();
        b = next_random_bit();
        return a | b;
    endfunction

    function automatic logic [63:0] fill_word(input logic [9:0] addr);
        logic [31:0] a;
        a = {22'h0, addr};
        return {a * 32'h9e37_79b9, a ^ 32'h5ac3_0000};
    endfunction

    // Legacy rate code to data bits per OFDM symbol
    function automatic int rate_dbps(input logic [3:0] rate);
        case (rate)
            4'b1011: return 24;
            4'b1111: return 36;
            4'b1010: return 48;
            4'b1110: return 72;
            4'b1001: return 96;
            4'b1101: return 144;
            4'b1000: return 192;
            4'b1100: return 216;
            default: return 24;
        endcase
    endfunction

    // x^7 + x^4 + 1 data scrambler
    function automatic logic scramble_bit(input logic data);
        logic fb;
        fb        = scr_state[6] ^ scr_state[3];
        scr_state = {scr_state[5:0], fb};
        return data ^ fb;
    endfunction

    task automatic load_record(inout int ptr);
        int n_bytes;
        int a;
        int b;
        pkt_rate = stim[ptr][3:0];
        pkt_len  = int'(stim[ptr + 1]);
        pkt_seed = stim[ptr + 2][6:0];
        if (pkt_len < 5 || pkt_len > 4095) begin
            $display("Stimulus record at entry %0d has an unusable length %0d", ptr, pkt_len);
            stop_with_failure();
        end
        ptr     = ptr + 3;
        n_bytes = pkt_len - 4;
        payload.delete();
        for (b = 0; b < n_bytes; b++) begin
            payload.push_back(stim[ptr + b][7:0]);
        end
        ptr       = ptr + n_bytes;
        pkt_fcs   = stim[ptr];
        pkt_pairs = int'(stim[ptr + 1]);
        ptr       = ptr + 2;
        for (a = 0; a < MEM_DEPTH; a++) begin
            pkt_mem[a] = fill_word(10'(a));
        end
        // SIGNAL word with even parity over bits 16:0
        pkt_sig       = 24'h0;
        pkt_sig[3:0]  = pkt_rate;
        pkt_sig[16:5] = pkt_len[11:0];
        pkt_sig[17]   = ^pkt_sig[16:0];
        pkt_mem[0][23:0] = pkt_sig;
        for (b = 0; b < n_bytes; b++) begin
            pkt_mem[1 + b / 8][(b % 8) * 8 +: 8] = payload[b];
        end
    endtask

    task automatic build_expected();
        logic [31:0] crc;
        logic [31:0] fcs;
        logic [7:0]  byte_v;
        logic        fb;
        int          n_dbps;
        int          data_len;
        int          n_sym;
        int          b;
        int          j;
        crc = 32'hffff_ffff;
        for (b = 0; b < payload.size(); b++) begin
            byte_v = payload[b];
            for (j = 0; j < 8; j++) begin
                fb  = crc[0] ^ byte_v[j];
                crc = crc >> 1;
                if (fb) begin
                    crc = crc ^ 32'hedb8_8320;
                end
            end
        end
        fcs = ~crc;
        check_value("FCS", 64'(fcs), 64'(pkt_fcs));
        n_dbps   = rate_dbps(pkt_rate);
        data_len = 16 + 8 * pkt_len + 6;
        n_sym    = (data_len + n_dbps - 1) / n_dbps;
        check_value("pair count", 64'(24 + n_sym * n_dbps), 64'(pkt_pairs));

        exp_bits.delete();
        for (j = 0; j < 24; j++) begin
            exp_bits.push_back(pkt_sig[j]);
        end
        scr_state = pkt_seed;
        for (j = 0; j < 16; j++) begin
            exp_bits.push_back(scramble_bit(1'b0));
        end
        for (b = 0; b < payload.size(); b++) begin
            byte_v = payload[b];
            for (j = 0; j < 8; j++) begin
                exp_bits.push_back(scramble_bit(byte_v[j]));
            end
        end
        for (j = 0; j < 32; j++) begin
            exp_bits.push_back(scramble_bit(fcs[j]));
        end
        // Tail leaves the scrambler untouched
        for (j = 0; j < 6; j++) begin
            exp_bits.push_back(1'b0);
        end
        for (j = 0; j < n_sym * n_dbps - data_len; j++) begin
            exp_bits.push_back(scramble_bit(1'b0));
        end
    endtask

    // K=7 code, d[k] holds the input from k bits ago
    task automatic encode_expected();
        logic [6:1] d;
        logic       x;
        int         n;
        exp_pairs.delete();
        d = '0;
        for (n = 0; n < exp_bits.size(); n++) begin
            // DATA starts from an empty history
            if (n == 24) begin
                d = '0;
            end
            x = exp_bits[n];
            exp_pairs.push_back({x ^ d[1] ^ d[2] ^ d[3] ^ d[6],
                                 x ^ d[2] ^ d[3] ^ d[5] ^ d[6]});
            d = {d[5:1], x};
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus and checking
    ////////////////////////////////////////////////////////////////////////////
    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (reset_int !== 1'b0 && cycles < RESET_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (reset_int !== 1'b0) begin
            $display("Reset was not released within %0d cycles", RESET_LIMIT);
            stop_with_failure();
        end
    endtask

    task automatic check_quiet_idle();
        int i;
        for (i = 0; i < IDLE_CHECKS; i++) begin
            check_value("o_valid", 64'(o_valid), 64'd0);
            check_value("o_busy", 64'(o_busy), 64'd0);
            check_value("o_done", 64'(o_done), 64'd0);
            check_value("o_mem_addr", 64'(o_mem_addr), 64'd0);
            @(negedge clk);
        end
    endtask

    task automatic run_packet();
        int         idx;
        int         cycles;
        int         limit;
        logic       stalled;
        logic       finished;
        logic [1:0] held;
        string      name;
        idx      = 0;
        cycles   = 0;
        limit    = 8 * exp_pairs.size() + 64;
        stalled  = 1'b0;
        finished = 1'b0;
        held     = 2'b00;
        @(posedge clk);
        #1;
        i_start      = 1'b1;
        i_scram_seed = pkt_seed;
        i_ready      = draw_ready();
        @(negedge clk);
        check_value("o_valid", 64'(o_valid), 64'd0);
        @(posedge clk);
        #1;
        i_start = 1'b0;
        i_ready = draw_ready();
        @(negedge clk);
        check_value("o_valid", 64'(o_valid), 64'd1);
        while (!finished) begin
            if (o_valid) begin
                check_value("o_done", 64'(o_done), 64'd0);
                check_value("o_busy", 64'(o_busy), 64'd1);
                if (stalled) begin
                    check_value("o_bits held", 64'(o_bits), 64'(held));
                end
                if (idx >= exp_pairs.size()) begin
                    $display("DUT presents more pairs than the packet holds");
                    stop_with_failure();
                end else if (i_ready) begin
                    name = (idx < 24) ? "o_bits SIGNAL" : "o_bits DATA";
                    check_value(name, 64'(o_bits), 64'(exp_pairs[idx]));
                    idx++;
                    stalled = 1'b0;
                end else begin
                    stalled = 1'b1;
                    held    = o_bits;
                end
            end else begin
                check_value("pairs transferred", 64'(idx), 64'(exp_pairs.size()));
                check_value("o_done", 64'(o_done), 64'd1);
                check_value("o_busy", 64'(o_busy), 64'd0);
                finished = 1'b1;
            end
            if (!finished) begin
                cycles++;
                if (cycles > limit) begin
                    $display("Packet did not complete within %0d cycles", limit);
                    stop_with_failure();
                end
                @(posedge clk);
                #1;
                i_ready = draw_ready();
                @(negedge clk);
            end
        end
        // Done is a single pulse
        @(posedge clk);
        #1;
        i_ready = draw_ready();
        @(negedge clk);
        check_value("o_done", 64'(o_done), 64'd0);
        check_value("o_valid", 64'(o_valid), 64'd0);
    endtask

    initial begin
        int ptr;
        int n_pkt;
        i_start      = 1'b0;
        i_scram_seed = 7'h00;
        i_ready      = 1'b0;
        rnd_state    = 32'h3c8c;
        for (ptr = 0; ptr < MEM_DEPTH; ptr++) begin
            pkt_mem[ptr] = fill_word(10'(ptr));
        end
        $readmemh("bench/dot11_bitgen_stim.txt", stim);
        wait_reset_release();
        check_quiet_idle();
        ptr   = 0;
        n_pkt = 0;
        while (stim[ptr][3:0] != 4'h0) begin
            load_record(ptr);
            build_expected();
            encode_expected();
            run_packet();
            n_pkt++;
        end
        if (n_pkt < 2) begin
            $display("Stimulus file holds fewer than two packets");
            stop_with_failure();
        end else begin
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule

// ==== dot11_bitgen.f ====
verilog/dot11_tx_pkg.sv
verilog/dot11_field_if.sv
verilog/dot11_frame_seq.sv
verilog/dot11_bit_source.sv
verilog/dot11_conv_enc.sv
verilog/dot11_bitgen_top.sv
bench/tb_clock_gen.sv
bench/tb_dot11_bitgen.sv

// ==== Makefile ====
# Verilator build for the 802.11a transmit bit generator testbench
VERILATOR ?= verilator
TOP       ?= tb_dot11_bitgen
FILELIST  ?= dot11_bitgen.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Exit status of the simulation binary is the pass or fail result
run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/dot11_bitgen_stim.txt ====
// One hex value per entry. Rate code, length in bytes with FCS, scrambler seed,
// then the payload bytes, the expected FCS and the expected pair count
// 6 Mbps, payload 123456789
b 0d 5d
31 32 33 34 35 36 37 38 39
cbf43926 a8
// 54 Mbps, a 43 byte sentence
c 2f 2b
54 68 65 20 71 75 69 63 6b 20 62 72 6f 77 6e 20 66 6f 78 20 6a 75
6d 70 73 20 6f 76 65 72 20 74 68 65 20 6c 61 7a 79 20 64 6f 67
414fa339 1c8
// 12 Mbps, payload abc
a 07 7f
61 62 63
352441c2 78
// A rate code of 0 ends the list
0
